/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= agu_array_tb
FILELIST  ?= agu_array.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* agu_array.f */
logic/agu_pkg.sv
logic/mem_pkg.sv
logic/agu_cfg_regs.sv
logic/agu_lane.sv
logic/lane_mem_bank.sv
logic/agu_array.sv
tb/agu_checker.sv
tb/agu_array_tb.sv

/* logic/agu_array.sv */
`default_nettype none

module agu_array #(
   parameter int n_lanes = 4,
   localparam int lane_w = (n_lanes > 1) ? $clog2(n_lanes) : 1
) (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          pause,

   input  logic                                          cfg_wr,
   input  logic [lane_w-1:0]                             cfg_lane,
   input  agu_pkg::cfg_field_t                           cfg_field,
   input  logic [agu_pkg::addr_w-1:0]                    cfg_data,

   input  logic                                          ctl_init,
   input  logic                                          ctl_run,
   input  logic [n_lanes-1:0]                            ctl_mask,

   input  logic                                          mem_wr,
   input  logic [lane_w-1:0]                             mem_lane,
   input  logic [agu_pkg::addr_w-1:0]                    mem_addr,
   input  logic [mem_pkg::data_w-1:0]                    mem_wdata,

   output logic [n_lanes-1:0][mem_pkg::data_w-1:0]       rd_data,
   output logic [n_lanes-1:0]                            rd_valid,
   output logic                                          all_done
);
   import agu_pkg::*;

   logic [n_lanes-1:0][addr_w-1:0] start;
   logic [n_lanes-1:0][addr_w-1:0] iterations;
   logic [n_lanes-1:0][period_w-1:0] period;
   logic [n_lanes-1:0][period_w-1:0] duty;
   logic [n_lanes-1:0][period_w-1:0] delay;
   logic [n_lanes-1:0][addr_w-1:0] incr;
   logic [n_lanes-1:0][addr_w-1:0] shift;
   logic [n_lanes-1:0] init;
   logic [n_lanes-1:0] run;

   logic [n_lanes-1:0][addr_w-1:0] addr;
   logic [n_lanes-1:0] mem_en;
   logic [n_lanes-1:0] done;

   agu_cfg_regs #(
      .n_lanes(n_lanes)
   ) agu_cfg_regs_inst (
      .clk, .rst,
      .cfg_wr, .cfg_lane, .cfg_field, .cfg_data,
      .ctl_init, .ctl_run, .ctl_mask,
      .start, .iterations, .period, .duty, .delay, .incr, .shift,
      .init, .run
   );

   for (genvar l = 0; l < n_lanes; l++) begin : g_lane
      agu_lane agu_lane_inst (
         .clk, .rst,
         .init       (init[l]),
         .run        (run[l]),
         .pause,
         .start      (start[l]),
         .iterations (iterations[l]),
         .period     (period[l]),
         .duty       (duty[l]),
         .delay      (delay[l]),
         .incr       (incr[l]),
         .shift      (shift[l]),
         .addr       (addr[l]),
         .mem_en     (mem_en[l]),
         .done       (done[l])
      );
   end

   lane_mem_bank #(
      .n_lanes(n_lanes)
   ) lane_mem_bank_inst (
      .clk, .rst,
      .mem_wr, .mem_lane, .mem_addr, .mem_wdata,
      .addr, .mem_en, .done,
      .rd_data, .rd_valid, .all_done
   );

endmodule

`default_nettype wire

/* logic/agu_cfg_regs.sv */
`default_nettype none

module agu_cfg_regs #(
   parameter int n_lanes = 4,
   localparam int lane_w = (n_lanes > 1) ? $clog2(n_lanes) : 1
) (
   input  logic                                          clk,
   input  logic                                          rst,

   input  logic                                          cfg_wr,
   input  logic [lane_w-1:0]                             cfg_lane,
   input  agu_pkg::cfg_field_t                           cfg_field,
   input  logic [agu_pkg::addr_w-1:0]                    cfg_data,

   input  logic                                          ctl_init,
   input  logic                                          ctl_run,
   input  logic [n_lanes-1:0]                            ctl_mask,

   output logic [n_lanes-1:0][agu_pkg::addr_w-1:0]       start,
   output logic [n_lanes-1:0][agu_pkg::addr_w-1:0]       iterations,
   output logic [n_lanes-1:0][agu_pkg::period_w-1:0]     period,
   output logic [n_lanes-1:0][agu_pkg::period_w-1:0]     duty,
   output logic [n_lanes-1:0][agu_pkg::period_w-1:0]     delay,
   output logic [n_lanes-1:0][agu_pkg::addr_w-1:0]       incr,
   output logic [n_lanes-1:0][agu_pkg::addr_w-1:0]       shift,
   output logic [n_lanes-1:0]                            init,
   output logic [n_lanes-1:0]                            run
);
   import agu_pkg::*;

   logic [period_w-1:0] cfg_short;

   assign cfg_short = cfg_data[period_w-1:0];   // period-sized fields

   // field registers, one set per lane
   always_ff @(posedge clk) begin
      for (int l = 0; l < n_lanes; l++) begin
         if (cfg_wr && cfg_lane == l) begin
            case (cfg_field)
               fld_start:      start[l] <= cfg_data;
               fld_iterations: iterations[l] <= cfg_data;
               fld_period:     period[l] <= cfg_short;
               fld_duty:       duty[l] <= cfg_short;
               fld_delay:      delay[l] <= cfg_short;
               fld_incr:       incr[l] <= cfg_data;
               fld_shift:      shift[l] <= cfg_data;
               default: ;
            endcase
         end
      end
   end

   // control strobes become one-cycle per-lane pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         init <= '0;
         run <= '0;
      end else begin
         init <= {n_lanes{ctl_init}} & ctl_mask;
         run <= {n_lanes{ctl_run}} & ctl_mask;
      end
   end

   a_cfg_lane_range: assert property (
      @(posedge clk) disable iff (rst)
      cfg_wr |-> (cfg_lane < n_lanes)
   ) else $error("config write to lane %0d, only %0d lanes", cfg_lane, n_lanes);

endmodule

`default_nettype wire

/* logic/agu_lane.sv */
`default_nettype none

module agu_lane (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 init,
   input  logic                                 run,
   input  logic                                 pause,

   input  logic [agu_pkg::addr_w-1:0]           start,
   input  logic [agu_pkg::addr_w-1:0]           iterations,
   input  logic [agu_pkg::period_w-1:0]         period,
   input  logic [agu_pkg::period_w-1:0]         duty,
   input  logic [agu_pkg::period_w-1:0]         delay,
   input  logic signed [agu_pkg::addr_w-1:0]    incr,
   input  logic signed [agu_pkg::addr_w-1:0]    shift,

   output logic [agu_pkg::addr_w-1:0]           addr,
   output logic                                 mem_en,
   output logic                                 done
);
   import agu_pkg::*;

   typedef enum logic {
      st_idle,
      st_run
   } state_t;

   localparam logic signed [period_w:0] one_s = 1;

   state_t state;

   // position inside the period, negative while the delay runs
   logic signed [period_w:0] per_cnt;
   logic signed [period_w:0] per_inc;
   logic signed [period_w:0] pos_nxt;
   logic signed [period_w:0] pos_first;
   logic signed [period_w:0] period_s;
   logic signed [period_w:0] duty_s;
   logic signed [period_w:0] delay_s;

   logic [addr_w-1:0] iter;        // current period index
   logic [addr_w-1:0] iter_inc;
   logic [addr_w-1:0] step_incr;
   logic [addr_w-1:0] step_shift;

   logic en_q;
   logic per_end;
   logic last;

   function automatic logic in_window(input logic signed [period_w:0] pos,
                                      input logic signed [period_w:0] width);
      return (pos >= 0) && (pos < width);
   endfunction

   assign period_s = signed'({1'b0, period});
   assign duty_s = signed'({1'b0, duty});
   assign delay_s = signed'({1'b0, delay});

   assign per_inc = per_cnt + one_s;
   assign per_end = (per_inc == period_s);          // last cycle of a period
   assign pos_nxt = per_end ? '0 : per_inc;
   assign iter_inc = iter + 1'b1;
   assign last = per_end && (iter_inc == iterations);

   // init and run may land together
   assign pos_first = init ? -delay_s : per_cnt;

   // a held slot is not reissued while paused
   assign mem_en = en_q && !pause;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         en_q <= 1'b0;
         done <= 1'b1;
         per_cnt <= '0;
         iter <= '0;
      end else begin
         case (state)
            st_idle: begin
               done <= 1'b1;
               if (init) begin
                  per_cnt <= -delay_s;
                  iter <= '0;
               end
               if (run) begin
                  state <= st_run;
                  done <= 1'b0;
                  en_q <= in_window(pos_first, duty_s);
               end
            end
            st_run: begin
               if (!pause) begin
                  per_cnt <= pos_nxt;
                  en_q <= !last && in_window(pos_nxt, duty_s);
                  if (per_end) iter <= iter_inc;
                  if (last) state <= st_idle;   // done follows a cycle later
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   assign step_incr = en_q ? incr : '0;
   assign step_shift = per_end ? shift : '0;

   // address accumulator
   always_ff @(posedge clk) begin
      if (state == st_idle) begin
         if (init) addr <= start;
      end else if (!pause) begin
         addr <= addr + step_incr + step_shift;
      end
   end

   a_idle_quiet: assert property (
      @(posedge clk) disable iff (rst)
      (state == st_idle) |-> !mem_en
   ) else $error("mem_en high in idle");

   a_duty_range: assert property (
      @(posedge clk) disable iff (rst)
      (state == st_idle && run) |-> (duty != '0 && duty <= period)
   ) else $error("run with duty %0d, period %0d", duty, period);

endmodule

`default_nettype wire

/* logic/agu_pkg.sv */
`default_nettype none

package agu_pkg;

   // address and iteration count width
   localparam int addr_w = 10;

   // period, duty and delay fields
   localparam int period_w = 6;

   // host config field select
   typedef enum logic [2:0] {
      fld_start      = 3'd0,
      fld_iterations = 3'd1,
      fld_period     = 3'd2,
      fld_duty       = 3'd3,
      fld_delay      = 3'd4,
      fld_incr       = 3'd5,   // signed
      fld_shift      = 3'd6    // signed
   } cfg_field_t;

endpackage

`default_nettype wire

/* logic/lane_mem_bank.sv */
`default_nettype none

module lane_mem_bank #(
   parameter int n_lanes = 4,
   localparam int lane_w = (n_lanes > 1) ? $clog2(n_lanes) : 1
) (
   input  logic                                          clk,
   input  logic                                          rst,

   // host preload
   input  logic                                          mem_wr,
   input  logic [lane_w-1:0]                             mem_lane,
   input  logic [agu_pkg::addr_w-1:0]                    mem_addr,
   input  logic [mem_pkg::data_w-1:0]                    mem_wdata,

   // from the lanes
   input  logic [n_lanes-1:0][agu_pkg::addr_w-1:0]       addr,
   input  logic [n_lanes-1:0]                            mem_en,
   input  logic [n_lanes-1:0]                            done,

   output logic [n_lanes-1:0][mem_pkg::data_w-1:0]       rd_data,
   output logic [n_lanes-1:0]                            rd_valid,
   output logic                                          all_done
);
   import mem_pkg::*;

   logic [data_w-1:0] bank [n_lanes][bank_depth];

   // host write and lane reads share one port set per bank
   always_ff @(posedge clk) begin
      for (int l = 0; l < n_lanes; l++) begin
         if (mem_wr && mem_lane == l) begin
            bank[l][mem_addr] <= mem_wdata;
         end
         if (mem_en[l]) begin
            rd_data[l] <= bank[l][addr[l]];   // old data on a collision
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid <= '0;
      end else begin
         rd_valid <= mem_en;
      end
   end

   assign all_done = &done;

   a_mem_lane_range: assert property (
      @(posedge clk) disable iff (rst)
      mem_wr |-> (mem_lane < n_lanes)
   ) else $error("preload to lane %0d, only %0d lanes", mem_lane, n_lanes);

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

   localparam int data_w = 16;

   // one word per agu address
   localparam int bank_depth = 2 ** agu_pkg::addr_w;

endpackage

`default_nettype wire

/* tb/agu_array_tb.sv */
`default_nettype none

module agu_array_tb;
   import agu_pkg::*;
   import mem_pkg::*;

   localparam int n_lanes = 4;
   localparam int lane_w = $clog2(n_lanes);
   localparam int wait_limit = 5000;   // cycles

   logic clk;
   logic rst;
   logic pause;
   logic cfg_wr;
   logic [lane_w-1:0] cfg_lane;
   cfg_field_t cfg_field;
   logic [addr_w-1:0] cfg_data;
   logic ctl_init;
   logic ctl_run;
   logic [n_lanes-1:0] ctl_mask;
   logic mem_wr;
   logic [lane_w-1:0] mem_lane;
   logic [addr_w-1:0] mem_addr;
   logic [data_w-1:0] mem_wdata;
   logic [n_lanes-1:0][data_w-1:0] rd_data;
   logic [n_lanes-1:0] rd_valid;
   logic all_done;

   integer seed = 32'haa27d6f9;
   int timeouts = 0;
   logic pause_on = 1'b0;

   logic [data_w-1:0] bank_model [n_lanes][bank_depth];   // preloaded contents
   logic [addr_w-1:0] c_start [n_lanes];
   logic [addr_w-1:0] c_iters [n_lanes];
   logic [addr_w-1:0] c_incr [n_lanes];
   logic [addr_w-1:0] c_shift [n_lanes];
   int c_duty [n_lanes];

   agu_array #(.n_lanes(n_lanes)) agu_array_inst (.*);
   agu_checker #(.n_lanes(n_lanes)) agu_checker_inst (.*);

   function automatic logic [addr_w-1:0] expected_addr(
      input logic [addr_w-1:0] start, input logic [addr_w-1:0] incr,
      input logic [addr_w-1:0] shift, input int duty, input int i, input int j);
      int a;
      a = int'(start) + i * int'($signed(shift)) + (i * duty + j) * int'($signed(incr));
      return a[addr_w-1:0];   // wraps like the address bus
   endfunction

   task automatic write_field(input int lane, input cfg_field_t field,
                              input logic [addr_w-1:0] value);
      cfg_wr = 1'b1;
      cfg_lane = lane[lane_w-1:0];
      cfg_field = field;
      cfg_data = value;
      @(negedge clk);
      cfg_wr = 1'b0;
   endtask

   task automatic configure_lane(input int lane, input logic [addr_w-1:0] start,
      input logic [addr_w-1:0] iters, input int period, input int duty, input int delay,
      input logic [addr_w-1:0] incr, input logic [addr_w-1:0] shift);
      c_start[lane] = start;
      c_iters[lane] = iters;
      c_duty[lane] = duty;
      c_incr[lane] = incr;
      c_shift[lane] = shift;
      write_field(lane, fld_start, start);
      write_field(lane, fld_iterations, iters);
      write_field(lane, fld_period, period[addr_w-1:0]);
      write_field(lane, fld_duty, duty[addr_w-1:0]);
      write_field(lane, fld_delay, delay[addr_w-1:0]);
      write_field(lane, fld_incr, incr);
      write_field(lane, fld_shift, shift);
   endtask

   task automatic random_lane(input int lane);
      int period;
      period = 1 + int'($unsigned($random(seed)) % 8);
      configure_lane(lane, addr_w'($random(seed)), addr_w'(1 + $unsigned($random(seed)) % 8),
                     period, 1 + int'($unsigned($random(seed)) % period),
                     int'($unsigned($random(seed)) % 6), addr_w'($random(seed)),
                     addr_w'($random(seed)));
   endtask

   task automatic queue_reads(input int lane);
      for (int i = 0; i < int'(c_iters[lane]); i++) begin
         for (int j = 0; j < c_duty[lane]; j++) begin
            agu_checker_inst.expect_word(lane, bank_model[lane][expected_addr(
               c_start[lane], c_incr[lane], c_shift[lane], c_duty[lane], i, j)]);
         end
      end
   endtask

   task automatic pulse_ctl(input logic init, input logic run, input logic [n_lanes-1:0] mask);
      ctl_init = init;
      ctl_run = run;
      ctl_mask = mask;
      @(negedge clk);
      ctl_init = 1'b0;
      ctl_run = 1'b0;
      ctl_mask = '0;
   endtask

   task automatic wait_all_done(input string name);
      int n;
      n = 0;
      while (all_done && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (all_done) begin
         $display("%s: the lanes never started", name);
         timeouts++;
      end else begin
         n = 0;
         while (!all_done && n < wait_limit) begin
            @(negedge clk);
            n++;
         end
         if (!all_done) begin
            $display("%s: the lanes never finished within %0d cycles", name, wait_limit);
            timeouts++;
         end
      end
      @(posedge clk);
      agu_checker_inst.check_drained();
      @(negedge clk);
   endtask

   task automatic run_lanes(input string name, input logic [n_lanes-1:0] init_mask,
                            input logic [n_lanes-1:0] run_mask);
      agu_checker_inst.begin_test(name);
      pulse_ctl(1'b1, 1'b0, init_mask);
      pulse_ctl(1'b0, 1'b1, run_mask);
      wait_all_done(name);
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // random pause stretches while pause_on is set
   initial begin : pause_gen
      int stretch;
      pause = 1'b0;
      stretch = 0;
      forever begin
         @(negedge clk);
         if (!pause_on) begin
            pause = 1'b0;
         end else if (stretch == 0) begin
            pause = ~pause;
            stretch = 1 + int'($unsigned($random(seed)) % 5);
         end else begin
            stretch--;
         end
      end
   end

   initial begin
      rst = 1'b1;
      cfg_wr = 1'b0;
      cfg_lane = '0;
      cfg_field = fld_start;
      cfg_data = '0;
      ctl_init = 1'b0;
      ctl_run = 1'b0;
      ctl_mask = '0;
      mem_wr = 1'b0;
      mem_lane = '0;
      mem_addr = '0;
      mem_wdata = '0;
      repeat (2) @(negedge clk);
      rst = 1'b0;

      for (int l = 0; l < n_lanes; l++) begin
         for (int a = 0; a < bank_depth; a++) begin
            bank_model[l][a] = data_w'($random(seed));
            mem_wr = 1'b1;
            mem_lane = l[lane_w-1:0];
            mem_addr = a[addr_w-1:0];
            mem_wdata = bank_model[l][a];
            @(negedge clk);
         end
      end
      mem_wr = 1'b0;

      configure_lane(0, 10'h040, 10'd6, 4, 4, 0, 10'd1, 10'd0);
      queue_reads(0);
      run_lanes("linear", 4'b0001, 4'b0001);

      configure_lane(1, 10'h300, 10'd5, 7, 3, 4, 10'd2, 10'h3f7);   // shift of -9
      queue_reads(1);
      run_lanes("gapped", 4'b0010, 4'b0010);

      for (int l = 0; l < n_lanes; l++) begin
         random_lane(l);
         queue_reads(l);
      end
      run_lanes("all lanes", '1, '1);

      for (int l = 0; l < n_lanes; l++) begin
         random_lane(l);
         queue_reads(l);
      end
      pause_on = 1'b1;
      run_lanes("paused", '1, '1);
      pause_on = 1'b0;

      // other lanes get init but no run, so they must stay silent
      configure_lane(2, 10'h3fc, 10'd3, 5, 2, 1, 10'h3ff, 10'd7);
      queue_reads(2);
      run_lanes("restart first", '1, 4'b0100);
      queue_reads(2);
      run_lanes("restart second", 4'b0100, 4'b0100);

      $display("reads %0d, errors %0d, timeouts %0d",
               agu_checker_inst.reads, agu_checker_inst.errors, timeouts);
      if (agu_checker_inst.errors == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/agu_checker.sv */
`default_nettype none

module agu_checker #(
   parameter int n_lanes = 4
) (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic                                       pause,
   input  logic [n_lanes-1:0][mem_pkg::data_w-1:0]    rd_data,
   input  logic [n_lanes-1:0]                         rd_valid,
   input  logic                                       all_done
);
   import mem_pkg::*;

   logic [data_w-1:0] exp_q [n_lanes][$];   // expected words per lane
   string test_name = "none";
   int errors = 0;
   int reads = 0;
   logic pause_q = 1'b0;
   logic all_done_q = 1'b1;

   task automatic begin_test(input string name);
      test_name = name;
   endtask

   task automatic expect_word(input int lane, input logic [data_w-1:0] word);
      exp_q[lane].push_back(word);
   endtask

   // called once all_done is back high
   task automatic check_drained();
      for (int l = 0; l < n_lanes; l++) begin
         if (exp_q[l].size() != 0) begin
            $display("%s: lane %0d finished with %0d reads missing",
                     test_name, l, exp_q[l].size());
            errors++;
            exp_q[l].delete();
         end
      end
   endtask

   always @(posedge clk) begin
      pause_q <= pause;
   end

   // outputs settle after the rising edge, compare on the falling one
   always @(negedge clk) begin : compare
      logic [data_w-1:0] want;
      if (!rst) begin
         // every word is in before all_done rises
         if (all_done && !all_done_q) begin
            for (int l = 0; l < n_lanes; l++) begin
               if (exp_q[l].size() != 0) begin
                  $display("%s: all_done rose with %0d reads still due on lane %0d",
                           test_name, exp_q[l].size(), l);
                  errors++;
               end
            end
         end
         if (pause_q && rd_valid != '0) begin
            $display("%s: read data arrived after a whole paused cycle", test_name);
            errors++;
         end
         for (int l = 0; l < n_lanes; l++) begin
            if (rd_valid[l] && exp_q[l].size() == 0) begin
               $display("%s: unexpected read on lane %0d", test_name, l);
               errors++;
            end else if (rd_valid[l]) begin
               want = exp_q[l].pop_front();
               reads++;
               if (rd_data[l] !== want) begin
                  $display("error %s lane %0d expected %h actual %h",
                           test_name, l, want, rd_data[l]);
                  errors++;
               end
            end
         end
      end
      all_done_q = all_done;
   end

endmodule

`default_nettype wire
